/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_lc4_pipeline -f lc4_pipeline.f -o tb_sim
	./obj_dir/tb_sim

clean:
	rm -rf obj_dir

/* lc4_pipeline.f */
source/lc4_pkg.sv
source/lc4_decoder.sv
source/lc4_regfile.sv
source/lc4_alu.sv
source/lc4_hazard_unit.sv
source/lc4_branch_unit.sv
source/lc4_pipeline.sv
tests/tb_lc4_pipeline.sv

/* source/lc4_alu.sv */
`timescale 1ns/1ps

module lc4_alu
    import lc4_pkg::*;
(
    input  insn_u             i_insn,
    input  logic [WORD_W-1:0] i_pc,
    input  logic [WORD_W-1:0] i_rs_data,
    input  logic [WORD_W-1:0] i_rt_data,
    output logic [WORD_W-1:0] o_result,
    output logic [WORD_W-1:0] o_target
);

    logic [WORD_W-1:0] imm5_sx;    // ADD immediate
    logic [WORD_W-1:0] off6_sx;    // load/store offset
    logic [WORD_W-1:0] imm9_sx;    // branch offset or CONST value
    logic [3:0]        opcode;
    logic [2:0]        sub;

    assign opcode  = i_insn.arith.opcode;
    assign sub     = {i_insn.arith.imm_f, i_insn.arith.field[4:3]};
    assign imm5_sx = {{(WORD_W-5){i_insn.arith.field[4]}}, i_insn.arith.field};
    assign off6_sx = {{(WORD_W-6){i_insn.mem.off6[5]}}, i_insn.mem.off6};
    assign imm9_sx = {{(WORD_W-9){i_insn.br.off9[8]}}, i_insn.br.off9};

    always_comb begin
        o_result = '0;
        if ((opcode == OP_ADDI) && i_insn.arith.imm_f) begin
            o_result = i_rs_data + imm5_sx;
        end else if (opcode == OP_ARITH) begin
            case (sub)
                SUB_ADD: o_result = i_rs_data + i_rt_data;
                SUB_SUB: o_result = i_rs_data - i_rt_data;
                SUB_AND: o_result = i_rs_data & i_rt_data;
                SUB_OR:  o_result = i_rs_data | i_rt_data;
                default: o_result = '0;
            endcase
        end else if ((opcode == OP_LDR) || (opcode == OP_STR)) begin
            o_result = i_rs_data + off6_sx;    // effective address
        end else if (opcode == OP_CONST) begin
            o_result = imm9_sx;
        end
    end

    // PC + 1 + offset9 used only when the branch is taken
    assign o_target = i_pc + WORD_W'(1) + imm9_sx;

endmodule

/* source/lc4_branch_unit.sv */
`timescale 1ns/1ps

module lc4_branch_unit
    import lc4_pkg::*;
(
    input  logic              gwe,
    input  logic              i_rst_n,
    input  ctrl_t             i_ex_ctrl,
    input  insn_u             i_ex_insn,
    input  logic [WORD_W-1:0] i_alu_result,
    input  logic              i_mem_is_load,
    input  logic [WORD_W-1:0] i_mem_load_data,
    output logic              o_taken,
    output logic [2:0]        o_nzp
);

    logic [2:0] nzp_q;    // zero after reset so nothing is taken early
    logic [2:0] alu_flags;
    logic [2:0] ld_flags;

    function automatic logic [2:0] flags_of(input logic [WORD_W-1:0] v);
        logic [2:0] f;
        if (v[WORD_W-1]) begin
            f = 3'b100;
        end else if (v == '0) begin
            f = 3'b010;
        end else begin
            f = 3'b001;
        end
        return f;
    endfunction

    assign alu_flags = flags_of(i_alu_result);
    assign ld_flags  = flags_of(i_mem_load_data);

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            nzp_q <= '0;
        end else if (i_ex_ctrl.nzp_we && !i_ex_ctrl.is_load) begin
            nzp_q <= alu_flags;    // younger writer wins
        end else if (i_mem_is_load) begin
            nzp_q <= ld_flags;
        end
    end

    assign o_taken = i_ex_ctrl.is_branch && |(i_ex_insn.br.nzp & nzp_q);
    // flags as set by the memory-stage instruction
    assign o_nzp   = i_mem_is_load ? ld_flags : nzp_q;

endmodule

/* source/lc4_decoder.sv */
`timescale 1ns/1ps

module lc4_decoder
    import lc4_pkg::*;
(
    input  insn_u i_insn,
    output ctrl_t o_ctrl
);

    always_comb begin
        o_ctrl = '0;    // unknown opcodes stay a nop
        case (i_insn.arith.opcode)
            OP_BR: begin
                o_ctrl.is_branch = 1'b1;    // mask is tested in execute
            end

            OP_ARITH: begin    // register forms and ADD imm5
                o_ctrl.rs     = i_insn.arith.rs;
                o_ctrl.rs_re  = 1'b1;
                o_ctrl.rt     = i_insn.arith.field[2:0];
                o_ctrl.rt_re  = ~i_insn.arith.imm_f;   // no rt in the imm form
                o_ctrl.rd     = i_insn.arith.rd;
                o_ctrl.rd_we  = 1'b1;
                o_ctrl.nzp_we = 1'b1;
            end

            OP_LDR: begin
                o_ctrl.rs      = i_insn.mem.base;
                o_ctrl.rs_re   = 1'b1;
                o_ctrl.rd      = i_insn.mem.rd;
                o_ctrl.rd_we   = 1'b1;
                o_ctrl.nzp_we  = 1'b1;    // flags come from the loaded word
                o_ctrl.is_load = 1'b1;
            end

            OP_STR: begin
                o_ctrl.rs       = i_insn.mem.base;
                o_ctrl.rs_re    = 1'b1;
                // store source rides the rt port
                o_ctrl.rt       = i_insn.mem.rd;
                o_ctrl.rt_re    = 1'b1;
                o_ctrl.is_store = 1'b1;
            end

            OP_CONST: begin
                o_ctrl.rd     = i_insn.br.nzp;    // rd sits where the mask would be
                o_ctrl.rd_we  = 1'b1;
                o_ctrl.nzp_we = 1'b1;
            end

            default: begin
                o_ctrl = '0;
            end
        endcase
    end

    // a store never writes a register
    always_comb begin
        assert (!(o_ctrl.rd_we && o_ctrl.is_store))
            else $error("decoder: store decoded with rd_we set");
    end

endmodule

/* source/lc4_hazard_unit.sv */
`timescale 1ns/1ps

module lc4_hazard_unit
    import lc4_pkg::*;
(
    input  ctrl_t    i_dec_ctrl,
    input  ctrl_t    i_ex_ctrl,
    input  ctrl_t    i_mem_ctrl,
    input  ctrl_t    i_wb_ctrl,
    output byp_sel_e o_rs_sel,
    output byp_sel_e o_rt_sel,
    output logic     o_store_wm,
    output logic     o_stall
);

    logic mem_fwd_ok;    // memory stage has an ALU result headed for rd
    logic ld_rs_hit;
    logic ld_rt_hit;

    // a load in memory has no value yet, so it is left out of MX
    assign mem_fwd_ok = i_mem_ctrl.rd_we && !i_mem_ctrl.is_load;

    function automatic byp_sel_e pick_src(input logic re, input logic [REG_W-1:0] src);
        byp_sel_e sel;
        sel = BYP_RF;
        if (re && mem_fwd_ok && (i_mem_ctrl.rd == src)) begin
            sel = BYP_MEM;    // newest producer first
        end else if (re && i_wb_ctrl.rd_we && (i_wb_ctrl.rd == src)) begin
            sel = BYP_WB;
        end
        return sel;
    endfunction

    always_comb begin
        o_rs_sel = pick_src(i_ex_ctrl.rs_re, i_ex_ctrl.rs);
        o_rt_sel = pick_src(i_ex_ctrl.rt_re, i_ex_ctrl.rt);
    end

    // store data patched in memory from the writeback value
    assign o_store_wm = i_mem_ctrl.is_store && i_wb_ctrl.rd_we && (i_wb_ctrl.rd == i_mem_ctrl.rt);

    assign ld_rs_hit = i_dec_ctrl.rs_re && (i_dec_ctrl.rs == i_ex_ctrl.rd);
    assign ld_rt_hit = i_dec_ctrl.rt_re && !i_dec_ctrl.is_store     // store data goes via WM
                       && (i_dec_ctrl.rt == i_ex_ctrl.rd);

    // a branch waits for the load's flags
    assign o_stall = i_ex_ctrl.is_load && (ld_rs_hit || ld_rt_hit || i_dec_ctrl.is_branch);

    always_comb begin
        assert (!o_stall || (i_ex_ctrl.is_load && i_ex_ctrl.rd_we))
            else $error("hazard: stall without a load in execute");
    end

endmodule

/* source/lc4_pipeline.sv */
`timescale 1ns/1ps

module lc4_pipeline
    import lc4_pkg::*;
(
    input  logic              gwe,
    input  logic              i_rst_n,
    output logic [WORD_W-1:0] o_imem_addr,
    input  logic [WORD_W-1:0] i_imem_insn,
    output logic [WORD_W-1:0] o_dmem_addr,
    output logic              o_dmem_we,
    output logic [WORD_W-1:0] o_dmem_wdata,
    input  logic [WORD_W-1:0] i_dmem_rdata,
    output retire_t           o_retire
);

    logic [WORD_W-1:0] pc_q;
    logic [WORD_W-1:0] pc_next;
    logic              stall;
    logic              taken;

    logic              d_valid_q;
    logic [WORD_W-1:0] d_pc_q;
    insn_u             d_insn_q;
    ctrl_t             d_dec_ctrl;    // raw decoder output
    ctrl_t             d_ctrl;
    logic [WORD_W-1:0] d_rs_data;
    logic [WORD_W-1:0] d_rt_data;

    logic              x_valid_q;
    logic [WORD_W-1:0] x_pc_q;
    insn_u             x_insn_q;
    ctrl_t             x_ctrl_q;
    logic [WORD_W-1:0] x_rs_data_q;
    logic [WORD_W-1:0] x_rt_data_q;
    logic [WORD_W-1:0] x_rs_val;      // after bypass
    logic [WORD_W-1:0] x_rt_val;
    logic [WORD_W-1:0] x_result;
    logic [WORD_W-1:0] x_target;
    byp_sel_e          rs_sel;
    byp_sel_e          rt_sel;

    logic              m_valid_q;
    logic [WORD_W-1:0] m_pc_q;
    insn_u             m_insn_q;
    ctrl_t             m_ctrl_q;
    logic [WORD_W-1:0] m_result_q;
    logic [WORD_W-1:0] m_store_data_q;
    logic [WORD_W-1:0] m_store_data;
    logic              m_mem_op;
    logic              store_wm;
    logic [2:0]        m_nzp;

    logic              w_valid_q;
    logic [WORD_W-1:0] w_pc_q;
    insn_u             w_insn_q;
    ctrl_t             w_ctrl_q;
    logic [WORD_W-1:0] w_result_q;
    logic [WORD_W-1:0] w_mem_data_q;  // loaded word or store data
    logic [2:0]        w_nzp_q;
    logic [WORD_W-1:0] w_value;

    function automatic logic [WORD_W-1:0] fwd(input byp_sel_e sel,
                                              input logic [WORD_W-1:0] rf_val,
                                              input logic [WORD_W-1:0] mem_val,
                                              input logic [WORD_W-1:0] wb_val);
        logic [WORD_W-1:0] v;
        case (sel)
            BYP_MEM: v = mem_val;
            BYP_WB:  v = wb_val;
            default: v = rf_val;
        endcase
        return v;
    endfunction

    lc4_decoder u_decoder (.i_insn(d_insn_q), .o_ctrl(d_dec_ctrl));

    assign d_ctrl = d_valid_q ? d_dec_ctrl : '0;    // flushed slot decodes as a bubble

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_rst_n   (i_rst_n),
        .i_rs      (d_ctrl.rs),
        .i_rt      (d_ctrl.rt),
        .i_rd      (w_ctrl_q.rd),
        .i_we      (w_ctrl_q.rd_we),
        .i_wdata   (w_value),
        .o_rs_data (d_rs_data),
        .o_rt_data (d_rt_data)
    );

    lc4_hazard_unit u_hazard (
        .i_dec_ctrl (d_ctrl),
        .i_ex_ctrl  (x_ctrl_q),
        .i_mem_ctrl (m_ctrl_q),
        .i_wb_ctrl  (w_ctrl_q),
        .o_rs_sel   (rs_sel),
        .o_rt_sel   (rt_sel),
        .o_store_wm (store_wm),
        .o_stall    (stall)
    );

    assign x_rs_val = fwd(rs_sel, x_rs_data_q, m_result_q, w_value);
    assign x_rt_val = fwd(rt_sel, x_rt_data_q, m_result_q, w_value);

    lc4_alu u_alu (
        .i_insn    (x_insn_q),
        .i_pc      (x_pc_q),
        .i_rs_data (x_rs_val),
        .i_rt_data (x_rt_val),
        .o_result  (x_result),
        .o_target  (x_target)
    );

    lc4_branch_unit u_branch (
        .gwe             (gwe),
        .i_rst_n         (i_rst_n),
        .i_ex_ctrl       (x_ctrl_q),
        .i_ex_insn       (x_insn_q),
        .i_alu_result    (x_result),
        .i_mem_is_load   (m_ctrl_q.is_load),
        .i_mem_load_data (i_dmem_rdata),
        .o_taken         (taken),
        .o_nzp           (m_nzp)
    );

    // flush outranks stall
    assign pc_next     = taken ? x_target : (stall ? pc_q : pc_q + WORD_W'(1));
    assign o_imem_addr = pc_q;

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q      <= RESET_PC;
            d_valid_q <= 1'b0;
            x_valid_q <= 1'b0;
            x_ctrl_q  <= '0;
            m_valid_q <= 1'b0;
            m_ctrl_q  <= '0;
            w_valid_q <= 1'b0;
            w_ctrl_q  <= '0;
        end else begin
            pc_q <= pc_next;
            if (taken) begin
                d_valid_q <= 1'b0;    // wrong-path fetch
            end else if (!stall) begin
                d_valid_q <= 1'b1;
            end
            if (taken || stall) begin
                x_valid_q <= 1'b0;    // bubble into execute
                x_ctrl_q  <= '0;
            end else begin
                x_valid_q <= d_valid_q;
                x_ctrl_q  <= d_ctrl;
            end
            m_valid_q <= x_valid_q;
            m_ctrl_q  <= x_ctrl_q;
            w_valid_q <= m_valid_q;
            w_ctrl_q  <= m_ctrl_q;
        end
    end

    always_ff @(posedge gwe) begin
        if (!stall) begin    // decode holds on a load-use stall
            d_pc_q   <= pc_q;
            d_insn_q <= i_imem_insn;
        end
        x_pc_q         <= d_pc_q;
        x_insn_q       <= d_insn_q;
        x_rs_data_q    <= d_rs_data;
        x_rt_data_q    <= d_rt_data;
        m_pc_q         <= x_pc_q;
        m_insn_q       <= x_insn_q;
        m_result_q     <= x_result;
        m_store_data_q <= x_rt_val;
        w_pc_q         <= m_pc_q;
        w_insn_q       <= m_insn_q;
        w_result_q     <= m_result_q;
        w_mem_data_q   <= m_ctrl_q.is_load ? i_dmem_rdata : o_dmem_wdata;
        w_nzp_q        <= m_nzp;
    end

    assign m_mem_op     = m_ctrl_q.is_load || m_ctrl_q.is_store;
    assign m_store_data = store_wm ? w_value : m_store_data_q;    // WM
    assign o_dmem_addr  = m_mem_op ? m_result_q : '0;
    assign o_dmem_we    = m_ctrl_q.is_store;
    assign o_dmem_wdata = m_ctrl_q.is_store ? m_store_data : '0;

    assign w_value = w_ctrl_q.is_load ? w_mem_data_q : w_result_q;

    always_comb begin
        o_retire.valid     = w_valid_q;
        o_retire.pc        = w_pc_q;
        o_retire.insn      = w_insn_q;
        o_retire.rd_we     = w_ctrl_q.rd_we;
        o_retire.rd        = w_ctrl_q.rd;
        o_retire.rd_data   = w_value;
        o_retire.nzp_we    = w_ctrl_q.nzp_we;
        o_retire.nzp       = w_nzp_q;
        o_retire.dmem_we   = w_ctrl_q.is_store;
        o_retire.dmem_addr = (w_ctrl_q.is_load || w_ctrl_q.is_store) ? w_result_q : '0;
        o_retire.dmem_data = w_mem_data_q;
    end

    a_retire_pc_known: assert property (@(posedge gwe) disable iff (!i_rst_n)
        o_retire.valid |-> !$isunknown(o_retire.pc))
        else $error("pipeline: retire valid with unknown pc");

endmodule

/* source/lc4_pkg.sv */
package lc4_pkg;

    localparam int WORD_W   = 16;   // data and address width
    localparam int REG_W    = 3;    // register index width
    localparam int NUM_REGS = 8;

    localparam logic [WORD_W-1:0] RESET_PC = 16'h8200;   // first fetch address

    // major opcodes live in insn[15:12]
    localparam logic [3:0] OP_BR    = 4'b0000;
    localparam logic [3:0] OP_ARITH = 4'b0001;
    localparam logic [3:0] OP_ADDI  = 4'b0001;   // arith major with insn[5] set
    localparam logic [3:0] OP_LDR   = 4'b0110;
    localparam logic [3:0] OP_STR   = 4'b0111;
    localparam logic [3:0] OP_CONST = 4'b1001;

    // register-form subcodes, taken from {insn[5], insn[4:3]}
    localparam logic [2:0] SUB_ADD = 3'b000;
    localparam logic [2:0] SUB_AND = 3'b001;
    localparam logic [2:0] SUB_SUB = 3'b010;
    localparam logic [2:0] SUB_OR  = 3'b011;

    typedef struct packed {
        logic [3:0]       opcode;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs;
        logic             imm_f;    // set for the imm5 form
        logic [4:0]       field;    // {sub[1:0], rt} or imm5
    } insn_arith_t;

    typedef struct packed {
        logic [3:0]       opcode;
        logic [REG_W-1:0] rd;       // load target or store source
        logic [REG_W-1:0] base;
        logic [5:0]       off6;
    } insn_mem_t;

    // CONST reuses this layout with nzp as rd and off9 as imm9
    typedef struct packed {
        logic [3:0] opcode;
        logic [2:0] nzp;
        logic [8:0] off9;
    } insn_br_t;

    typedef union packed {
        insn_arith_t arith;
        insn_mem_t   mem;
        insn_br_t    br;
    } insn_u;

    typedef struct packed {
        logic [REG_W-1:0] rs;
        logic [REG_W-1:0] rt;
        logic [REG_W-1:0] rd;
        logic             rs_re;
        logic             rt_re;
        logic             rd_we;
        logic             nzp_we;
        logic             is_load;
        logic             is_store;
        logic             is_branch;
    } ctrl_t;

    // one record per retired instruction, built in writeback
    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] pc;
        logic [WORD_W-1:0] insn;
        logic              rd_we;
        logic [REG_W-1:0]  rd;
        logic [WORD_W-1:0] rd_data;
        logic              nzp_we;
        logic [2:0]        nzp;
        logic              dmem_we;
        logic [WORD_W-1:0] dmem_addr;
        logic [WORD_W-1:0] dmem_data;   // store data or loaded word
    } retire_t;

    typedef enum logic [1:0] {
        BYP_RF  = 2'd0,   // operand from the decode-stage read
        BYP_MEM = 2'd1,   // MX
        BYP_WB  = 2'd2    // WX
    } byp_sel_e;

endpackage

/* source/lc4_regfile.sv */
`timescale 1ns/1ps

module lc4_regfile
    import lc4_pkg::*;
(
    input  logic              gwe,
    input  logic              i_rst_n,
    input  logic [REG_W-1:0]  i_rs,
    input  logic [REG_W-1:0]  i_rt,
    input  logic [REG_W-1:0]  i_rd,
    input  logic              i_we,
    input  logic [WORD_W-1:0] i_wdata,
    output logic [WORD_W-1:0] o_rs_data,
    output logic [WORD_W-1:0] o_rt_data
);

    logic [WORD_W-1:0] regs_q [NUM_REGS];

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (i_we) begin
            regs_q[i_rd] <= i_wdata;    // writeback port
        end
    end

    // writeback data shows through to decode in the same cycle
    assign o_rs_data = (i_we && (i_rd == i_rs)) ? i_wdata : regs_q[i_rs];
    assign o_rt_data = (i_we && (i_rd == i_rt)) ? i_wdata : regs_q[i_rt];

    a_wdata_known: assert property (@(posedge gwe) disable iff (!i_rst_n)
        i_we |-> !$isunknown(i_wdata))
        else $error("regfile: unknown write data to r%0d", i_rd);

endmodule

/* tests/lc4_stim.hex */
// program count, then program words from 8200
// data count, then address value pairs, then register count and expected r0..r7
001b
9010 9205 95fd 1642 18d1 1a09 1cdc 1fa3 7200
6401 1681 6800 7802 6a01 0801 9c63 0401 1c20
0202 9e01 9e02 0e00 1251 0a01 0401 9207 6202
0002
0011 fff9
0012 1234
0008
0010 0005 fff9 fffe 0005 fff9 0010 0002

/* tests/tb_lc4_pipeline.sv */
`timescale 1ns/1ps

module tb_lc4_pipeline
    import lc4_pkg::*;
();

    logic              gwe;
    logic              i_rst_n;
    logic [WORD_W-1:0] imem_addr;
    logic [WORD_W-1:0] imem_insn;
    logic [WORD_W-1:0] dmem_addr;
    logic              dmem_we;
    logic [WORD_W-1:0] dmem_wdata;
    logic [WORD_W-1:0] dmem_rdata;
    retire_t           retire;

    logic [WORD_W-1:0] imem [65536];   // program memory, full address space
    logic [WORD_W-1:0] dmem [65536];   // data memory seen by the DUT
    logic [WORD_W-1:0] mmem [65536];   // data memory of the reference model
    logic [WORD_W-1:0] stim [128];

    logic [WORD_W-1:0] mregs [NUM_REGS];     // model register file
    logic [WORD_W-1:0] last_val [NUM_REGS];  // last value each register retired with
    logic [2:0]        mnzp;
    logic [WORD_W-1:0] m_pc;
    logic [WORD_W-1:0] last_pc;
    int                n_prog;

    lc4_pipeline dut_i (
        .gwe          (gwe),
        .i_rst_n      (i_rst_n),
        .o_imem_addr  (imem_addr),
        .i_imem_insn  (imem_insn),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_we    (dmem_we),
        .o_dmem_wdata (dmem_wdata),
        .i_dmem_rdata (dmem_rdata),
        .o_retire     (retire)
    );

    always #5 gwe = ~gwe;

    // both memories answer in the same cycle
    assign imem_insn  = imem[imem_addr];
    assign dmem_rdata = dmem[dmem_addr];

    always @(posedge gwe) begin
        if (dmem_we) dmem[dmem_addr] <= dmem_wdata;   // store lands at the edge
    end

    task automatic check_eq(input string what, input logic [WORD_W-1:0] got,
                            input logic [WORD_W-1:0] exp);
        assert (got === exp)
            else begin
                $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
                $display("FAIL: see errors above");
                $fatal(1, "mismatch");
            end
    endtask

    function automatic logic [2:0] flags_for(input logic [WORD_W-1:0] v);
        if (v[WORD_W-1]) return 3'b100;
        if (v == '0) return 3'b010;
        return 3'b001;
    endfunction

    // one in-order step of the ISA model per retired instruction
    task automatic step_and_check();
        insn_u             w;
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] b;
        logic [WORD_W-1:0] val;
        logic [WORD_W-1:0] addr;
        logic              wr;
        logic              st;
        w    = imem[m_pc];
        check_eq("retire pc", retire.pc, m_pc);
        check_eq("retire insn", retire.insn, w);
        a    = mregs[w.arith.rs];
        b    = mregs[w.arith.field[2:0]];
        wr   = 1'b1;
        st   = 1'b0;
        val  = '0;
        addr = '0;
        case (w.arith.opcode)
            OP_ARITH: begin
                if (w.arith.imm_f) val = a + {{11{w.arith.field[4]}}, w.arith.field};
                else begin
                    case (w.arith.field[4:3])
                        2'b00:   val = a + b;
                        2'b01:   val = a & b;
                        2'b10:   val = a - b;
                        default: val = a | b;
                    endcase
                end
            end
            OP_CONST: val = {{7{w.br.off9[8]}}, w.br.off9};
            OP_LDR: begin
                addr = mregs[w.mem.base] + {{10{w.mem.off6[5]}}, w.mem.off6};
                val  = mmem[addr];
                check_eq("load address", retire.dmem_addr, addr);
                check_eq("load data", retire.dmem_data, val);
            end
            OP_STR: begin
                wr   = 1'b0;
                st   = 1'b1;
                addr = mregs[w.mem.base] + {{10{w.mem.off6[5]}}, w.mem.off6};
                mmem[addr] = mregs[w.mem.rd];
                check_eq("store address", retire.dmem_addr, addr);
                check_eq("store data", retire.dmem_data, mregs[w.mem.rd]);
            end
            default: wr = 1'b0;   // branch or nop
        endcase
        check_eq("retire dmem_we", {15'b0, retire.dmem_we}, {15'b0, st});
        check_eq("retire rd_we", {15'b0, retire.rd_we}, {15'b0, wr});
        // every register writer in this subset also sets the flags
        check_eq("retire nzp_we", {15'b0, retire.nzp_we}, {15'b0, wr});
        if (wr) begin
            check_eq("retire rd", {13'b0, retire.rd}, {13'b0, w.arith.rd});
            check_eq("retire rd_data", retire.rd_data, val);
            mregs[w.arith.rd]  = val;
            mnzp               = flags_for(val);
            check_eq("retire nzp", {13'b0, retire.nzp}, {13'b0, mnzp});
            last_val[retire.rd] = retire.rd_data;
        end
        if ((w.br.opcode == OP_BR) && |(w.br.nzp & mnzp)) begin
            m_pc = m_pc + 16'd1 + {{7{w.br.off9[8]}}, w.br.off9};   // taken
        end else begin
            m_pc = m_pc + 16'd1;
        end
    endtask

    initial begin
        int  p;
        int  n_data;
        int  exp_at;
        logic done;
        gwe     = 1'b0;
        i_rst_n = 1'b0;
        $readmemh("tests/lc4_stim.hex", stim);
        for (int i = 0; i < 65536; i++) begin
            imem[i] = '0;    // empty slots fetch as a never-taken BR
            dmem[i] = '0;
            mmem[i] = '0;
        end
        n_prog = int'(stim[0]);
        for (int i = 0; i < n_prog; i++) imem[RESET_PC + 16'(i)] = stim[1 + i];
        p      = 1 + n_prog;
        n_data = int'(stim[p]);
        p      = p + 1;
        for (int i = 0; i < n_data; i++) begin
            dmem[stim[p]] = stim[p + 1];
            mmem[stim[p]] = stim[p + 1];
            p = p + 2;
        end
        exp_at  = p + 1;   // skip the register count
        last_pc = RESET_PC + 16'(n_prog - 1);
        for (int r = 0; r < NUM_REGS; r++) begin
            mregs[r]    = '0;
            last_val[r] = '0;
        end
        mnzp = 3'b000;
        m_pc = RESET_PC;

        repeat (5) @(posedge gwe);
        i_rst_n <= 1'b1;

        done = 1'b0;
        while (!done) begin
            @(negedge gwe);   // retire record is stable mid-cycle
            if (retire.valid) begin
                step_and_check();
                if (retire.pc == last_pc) done = 1'b1;
            end
        end

        for (int r = 0; r < NUM_REGS; r++) begin
            check_eq($sformatf("model r%0d", r), mregs[r], stim[exp_at + r]);
            check_eq($sformatf("retired r%0d", r), last_val[r], stim[exp_at + r]);
        end
        $display("PASS: all tests");
        $finish;
    end

    // budget: five cycles per instruction plus ten
    initial begin
        wait (i_rst_n === 1'b1);
        repeat (n_prog * 5 + 10) @(posedge gwe);
        $display("timeout: the last program instruction never retired");
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

endmodule
